// File: src/nrv_soc_pkg.sv
//////////////////////////////////////////////////
// Shared definitions of the MCU bus fabric
// Widths, address map, bus bundles, slave codes
// and the byte strobe decode
//////////////////////////////////////////////////

package nrv_soc_pkg;

   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 32;
   localparam int PERIPH_AW = 12;              // 4 KB peripheral window
   localparam int GPIO_W    = 16;              // Pad port width

   // Address map
   localparam logic [ADDR_W-1:0] TCM0_BASE   = 32'h0000_0000; // Code RAM
   localparam logic [ADDR_W-1:0] TCM1_BASE   = 32'h0001_0000; // Data RAM
   localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h8000_0000;

   localparam logic [PERIPH_AW-1:0] GPIO_OUT_OFS = 12'h000;
   localparam logic [PERIPH_AW-1:0] GPIO_IN_OFS  = 12'h004;

   typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} size_e;

   // Address phase of one master
   typedef struct packed {
      logic              valid;
      logic              write;
      size_e             size;
      logic [ADDR_W-1:0] addr;
   } ahb_req_t;

   // Back to the master
   typedef struct packed {
      logic              ready;                // Address accepted
      logic              resp;                 // Error in data phase
      logic [DATA_W-1:0] rdata;
   } ahb_rsp_t;

   // Plain strobes towards the peripherals
   typedef struct packed {
      logic                 en;                // One cycle per transfer
      logic                 write;
      logic [PERIPH_AW-1:0] addr;
      logic [3:0]           bytesel;
      logic [DATA_W-1:0]    din;
   } periph_req_t;

   typedef enum logic [1:0] {SLV_TCM0, SLV_TCM1, SLV_PERIPH, SLV_NONE} slave_e;

   // Byte lanes touched by a transfer
   function automatic logic [3:0] byte_strobe(size_e size, logic [1:0] ofs);
      case (size)
         SZ_BYTE: return 4'b0001 << ofs;
         SZ_HALF: return ofs[1] ? 4'b1100 : 4'b0011;
         default: return 4'b1111;
      endcase
   endfunction

endpackage

// File: src/nrv_ahb_matrix.sv
//////////////////////////////////////////////////
// Two master, three slave bus matrix
// Decodes each address phase, lets the data side
// win a collision and steers the data phases back
// Unmapped addresses complete with an error
//////////////////////////////////////////////////

module nrv_ahb_matrix #(
   parameter int RAM_AW = 16                   // Bytes per RAM, log2
) (
   input  logic                             clk,
   input  logic                             arst_n,
   input  nrv_soc_pkg::ahb_req_t            code_req,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   code_wdata,
   output nrv_soc_pkg::ahb_rsp_t            code_rsp,
   input  nrv_soc_pkg::ahb_req_t            data_req,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   data_wdata,
   output nrv_soc_pkg::ahb_rsp_t            data_rsp,
   output nrv_soc_pkg::ahb_req_t            tcm0_req,
   output logic [nrv_soc_pkg::DATA_W-1:0]   tcm0_wdata,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   tcm0_rdata,
   output nrv_soc_pkg::ahb_req_t            tcm1_req,
   output logic [nrv_soc_pkg::DATA_W-1:0]   tcm1_wdata,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   tcm1_rdata,
   output nrv_soc_pkg::ahb_req_t            periph_req,
   output logic [nrv_soc_pkg::DATA_W-1:0]   periph_wdata,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   periph_rdata
);

   localparam int AW = nrv_soc_pkg::ADDR_W;
   localparam int PW = nrv_soc_pkg::PERIPH_AW;

   nrv_soc_pkg::slave_e code_sel, data_sel;    // Address phase targets
   logic                conflict;              // Same slave, same cycle
   logic                code_pri_q;            // Code lost last cycle
   logic                code_rdy, data_rdy;
   logic                code_gnt, data_gnt;

   // Data phase owners
   nrv_soc_pkg::slave_e code_dp_slv_q, data_dp_slv_q;
   logic                code_dp_vld_q, data_dp_vld_q;

   function automatic nrv_soc_pkg::slave_e decode(logic [AW-1:0] addr);
      if (addr[AW-1:RAM_AW] == nrv_soc_pkg::TCM0_BASE[AW-1:RAM_AW])
         return nrv_soc_pkg::SLV_TCM0;
      if (addr[AW-1:RAM_AW] == nrv_soc_pkg::TCM1_BASE[AW-1:RAM_AW])
         return nrv_soc_pkg::SLV_TCM1;
      if (addr[AW-1:PW] == nrv_soc_pkg::PERIPH_BASE[AW-1:PW])
         return nrv_soc_pkg::SLV_PERIPH;
      return nrv_soc_pkg::SLV_NONE;
   endfunction

   // Granted address phase for one slave, idle otherwise
   function automatic nrv_soc_pkg::ahb_req_t pick_req(nrv_soc_pkg::slave_e tgt);
      if (data_gnt && data_sel == tgt) return data_req;
      if (code_gnt && code_sel == tgt) return code_req;
      return '0;
   endfunction

   // Write data follows whoever owns the slave's data phase
   function automatic logic [nrv_soc_pkg::DATA_W-1:0] pick_wdata(nrv_soc_pkg::slave_e tgt);
      if (data_dp_vld_q && data_dp_slv_q == tgt) return data_wdata;
      if (code_dp_vld_q && code_dp_slv_q == tgt) return code_wdata;
      return '0;
   endfunction

   function automatic logic [nrv_soc_pkg::DATA_W-1:0] slave_rdata(nrv_soc_pkg::slave_e slv);
      case (slv)
         nrv_soc_pkg::SLV_TCM0:   return tcm0_rdata;
         nrv_soc_pkg::SLV_TCM1:   return tcm1_rdata;
         nrv_soc_pkg::SLV_PERIPH: return periph_rdata;
         default:                 return '0;   // Unmapped reads zero
      endcase
   endfunction

   assign code_sel = decode(code_req.addr);
   assign data_sel = decode(data_req.addr);

   // Unmapped transfers never collide, no shared slave behind them
   assign conflict = code_req.valid && data_req.valid && code_sel == data_sel &&
                     code_sel != nrv_soc_pkg::SLV_NONE;

   assign data_rdy = !(conflict && code_pri_q);  // Loses only right after a code loss
   assign code_rdy = !(conflict && !code_pri_q);
   assign code_gnt = code_req.valid && code_rdy;
   assign data_gnt = data_req.valid && data_rdy;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         code_pri_q    <= 1'b0;
         code_dp_vld_q <= 1'b0;
         code_dp_slv_q <= nrv_soc_pkg::SLV_NONE;
         data_dp_vld_q <= 1'b0;
         data_dp_slv_q <= nrv_soc_pkg::SLV_NONE;
      end else begin
         code_pri_q    <= conflict && !code_pri_q;   // Code takes the next round
         code_dp_vld_q <= code_gnt;
         code_dp_slv_q <= code_sel;
         data_dp_vld_q <= data_gnt;
         data_dp_slv_q <= data_sel;
      end
   end

   always_comb begin
      tcm0_req     = pick_req(nrv_soc_pkg::SLV_TCM0);
      tcm1_req     = pick_req(nrv_soc_pkg::SLV_TCM1);
      periph_req   = pick_req(nrv_soc_pkg::SLV_PERIPH);
      tcm0_wdata   = pick_wdata(nrv_soc_pkg::SLV_TCM0);
      tcm1_wdata   = pick_wdata(nrv_soc_pkg::SLV_TCM1);
      periph_wdata = pick_wdata(nrv_soc_pkg::SLV_PERIPH);
   end

   always_comb begin
      code_rsp.ready = code_rdy;
      code_rsp.resp  = code_dp_vld_q && code_dp_slv_q == nrv_soc_pkg::SLV_NONE;
      code_rsp.rdata = code_dp_vld_q ? slave_rdata(code_dp_slv_q) : '0;
      data_rsp.ready = data_rdy;
      data_rsp.resp  = data_dp_vld_q && data_dp_slv_q == nrv_soc_pkg::SLV_NONE;
      data_rsp.rdata = data_dp_vld_q ? slave_rdata(data_dp_slv_q) : '0;
   end

   // Master must hold a stalled request
   a_code_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
      code_req.valid && !code_rsp.ready |=> $stable(code_req));

   // Never two data phases on one slave
   a_one_owner: assert property (@(posedge clk) disable iff (!arst_n)
      !(code_dp_vld_q && data_dp_vld_q && code_dp_slv_q == data_dp_slv_q &&
        code_dp_slv_q != nrv_soc_pkg::SLV_NONE));

endmodule

// File: src/nrv_tcm_ram.sv
//////////////////////////////////////////////////
// Zero-wait tightly coupled RAM slave
// Byte strobed writes at the end of the data
// phase, reads forwarded from a pending write
//////////////////////////////////////////////////

module nrv_tcm_ram #(
   parameter int RAM_AW = 16                   // Bytes, log2
) (
   input  logic                             clk,
   input  logic                             arst_n,
   input  nrv_soc_pkg::ahb_req_t            req,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   wdata,
   output logic [nrv_soc_pkg::DATA_W-1:0]   rdata
);

   localparam int WORDS = 2 ** (RAM_AW - 2);

   logic [nrv_soc_pkg::DATA_W-1:0] mem [WORDS];
   logic [nrv_soc_pkg::DATA_W-1:0] rd_q;

   logic                dp_vld_q, dp_wr_q;     // Data phase in flight
   logic [RAM_AW-3:0]   dp_idx_q;
   logic [3:0]          dp_strb_q;
   logic [RAM_AW-3:0]   idx;
   logic                wr_hit;

   // Overlay strobed bytes of new on old
   function automatic logic [nrv_soc_pkg::DATA_W-1:0] merge(
      logic [nrv_soc_pkg::DATA_W-1:0] old_w,
      logic [nrv_soc_pkg::DATA_W-1:0] new_w,
      logic [3:0]                     strb);
      logic [nrv_soc_pkg::DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   assign idx    = req.addr[RAM_AW-1:2];
   assign wr_hit = dp_vld_q && dp_wr_q && dp_idx_q == idx;  // Read behind write, same word

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dp_vld_q <= 1'b0;
         dp_wr_q  <= 1'b0;
      end else begin
         dp_vld_q <= req.valid;
         dp_wr_q  <= req.write;
      end
   end

   always_ff @(posedge clk) begin
      if (req.valid) begin
         dp_idx_q  <= idx;
         dp_strb_q <= nrv_soc_pkg::byte_strobe(req.size, req.addr[1:0]);
         if (!req.write) begin
            rd_q <= wr_hit ? merge(mem[idx], wdata, dp_strb_q) : mem[idx];
         end
      end
      if (dp_vld_q && dp_wr_q) mem[dp_idx_q] <= merge(mem[dp_idx_q], wdata, dp_strb_q);
   end

   assign rdata = rd_q;

   // Masters only issue size aligned transfers
   a_aligned: assert property (@(posedge clk) disable iff (!arst_n)
      req.valid |-> (req.size != nrv_soc_pkg::SZ_HALF || !req.addr[0]) &&
                    (req.size != nrv_soc_pkg::SZ_WORD || req.addr[1:0] == 2'b00));

endmodule

// File: src/nrv_periph_bridge.sv
//////////////////////////////////////////////////
// Bus to peripheral bridge
// Turns an accepted transfer into one enable
// strobe in the data phase, with byte select
//////////////////////////////////////////////////

module nrv_periph_bridge (
   input  logic                             clk,
   input  logic                             arst_n,
   input  nrv_soc_pkg::ahb_req_t            req,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   wdata,
   output logic [nrv_soc_pkg::DATA_W-1:0]   rdata,
   output nrv_soc_pkg::periph_req_t         preq,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   prdata
);

   logic                               en_q;   // Data phase strobe
   logic                               wr_q;
   logic [nrv_soc_pkg::PERIPH_AW-1:0]  addr_q; // Offset in window
   logic [3:0]                         sel_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         en_q <= 1'b0;
         wr_q <= 1'b0;
      end else begin
         en_q <= req.valid;
         wr_q <= req.valid && req.write;
      end
   end

   // Offset and lanes, sampled with the address phase
   always_ff @(posedge clk) begin
      if (req.valid) begin
         addr_q <= req.addr[nrv_soc_pkg::PERIPH_AW-1:0];
         sel_q  <= nrv_soc_pkg::byte_strobe(req.size, req.addr[1:0]);
      end
   end

   always_comb begin
      preq.en      = en_q;
      preq.write   = wr_q;
      preq.addr    = addr_q;
      preq.bytesel = sel_q;
      preq.din     = wdata;                    // Write data arrives in data phase
   end

   assign rdata = prdata;                      // Peripheral answers same cycle

endmodule

// File: src/nrv_gpio_regs.sv
//////////////////////////////////////////////////
// GPIO register block
// Byte writable output register on P0 and a
// synchronised input register from P1
//////////////////////////////////////////////////

module nrv_gpio_regs (
   input  logic                               clk,
   input  logic                               arst_n,
   input  nrv_soc_pkg::periph_req_t           preq,
   output logic [nrv_soc_pkg::DATA_W-1:0]     prdata,
   output logic [nrv_soc_pkg::GPIO_W-1:0]     gpio_p0,
   input  logic [nrv_soc_pkg::GPIO_W-1:0]     gpio_p1
);

   localparam int GW    = nrv_soc_pkg::GPIO_W;
   localparam int PW    = nrv_soc_pkg::PERIPH_AW;
   localparam int LANES = GW / 8;
   localparam int PAD_Z = nrv_soc_pkg::DATA_W - GW;

   logic [GW-1:0] out_q;                       // Drives P0
   logic [GW-1:0] sync1_q, sync2_q;            // P1 metastability stages
   logic [PW-1:0] reg_ofs;                     // Word offset, lanes come from bytesel
   logic          out_wr;

   assign reg_ofs = {preq.addr[PW-1:2], 2'b00};
   assign out_wr  = preq.en && preq.write && reg_ofs == nrv_soc_pkg::GPIO_OUT_OFS;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_q   <= '0;
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= gpio_p1;
         sync2_q <= sync1_q;
         for (int b = 0; b < LANES; b++) begin
            if (out_wr && preq.bytesel[b]) out_q[8*b +: 8] <= preq.din[8*b +: 8];
         end
      end
   end

   // Read mux, IN writes simply fall through
   always_comb begin
      prdata = '0;
      if (preq.en) begin
         case (reg_ofs)
            nrv_soc_pkg::GPIO_OUT_OFS: prdata = {{PAD_Z{1'b0}}, out_q};
            nrv_soc_pkg::GPIO_IN_OFS:  prdata = {{PAD_Z{1'b0}}, sync2_q};
            default:                   prdata = '0;
         endcase
      end
   end

   assign gpio_p0 = out_q;

endmodule

// File: src/nrv_soc_top.sv
//////////////////////////////////////////////////
// Memory and peripheral fabric of the MCU
// Matrix, code and data RAMs, bridge and GPIO
//////////////////////////////////////////////////

module nrv_soc_top (
   input  logic                             clk,
   input  logic                             arst_n,
   input  nrv_soc_pkg::ahb_req_t            code_req,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   code_wdata,
   output nrv_soc_pkg::ahb_rsp_t            code_rsp,
   input  nrv_soc_pkg::ahb_req_t            data_req,
   input  logic [nrv_soc_pkg::DATA_W-1:0]   data_wdata,
   output nrv_soc_pkg::ahb_rsp_t            data_rsp,
   output logic [nrv_soc_pkg::GPIO_W-1:0]   gpio_p0,
   input  logic [nrv_soc_pkg::GPIO_W-1:0]   gpio_p1
);

   localparam int RAM_AW = 16;                 // 64 KB per RAM

   nrv_soc_pkg::ahb_req_t          tcm0_req, tcm1_req, periph_req;
   logic [nrv_soc_pkg::DATA_W-1:0] tcm0_wdata, tcm1_wdata, periph_wdata;
   logic [nrv_soc_pkg::DATA_W-1:0] tcm0_rdata, tcm1_rdata, periph_rdata;
   nrv_soc_pkg::periph_req_t       gpio_preq;  // Bridge to GPIO strobes
   logic [nrv_soc_pkg::DATA_W-1:0] gpio_rdata;

   nrv_ahb_matrix #(.RAM_AW(RAM_AW)) u_matrix (
      .clk          (clk),
      .arst_n       (arst_n),
      .code_req     (code_req),
      .code_wdata   (code_wdata),
      .code_rsp     (code_rsp),
      .data_req     (data_req),
      .data_wdata   (data_wdata),
      .data_rsp     (data_rsp),
      .tcm0_req     (tcm0_req),
      .tcm0_wdata   (tcm0_wdata),
      .tcm0_rdata   (tcm0_rdata),
      .tcm1_req     (tcm1_req),
      .tcm1_wdata   (tcm1_wdata),
      .tcm1_rdata   (tcm1_rdata),
      .periph_req   (periph_req),
      .periph_wdata (periph_wdata),
      .periph_rdata (periph_rdata)
   );

   // Code RAM
   nrv_tcm_ram #(.RAM_AW(RAM_AW)) u_tcm0 (
      .clk (clk), .arst_n (arst_n),
      .req (tcm0_req), .wdata (tcm0_wdata), .rdata (tcm0_rdata)
   );

   // Data RAM
   nrv_tcm_ram #(.RAM_AW(RAM_AW)) u_tcm1 (
      .clk (clk), .arst_n (arst_n),
      .req (tcm1_req), .wdata (tcm1_wdata), .rdata (tcm1_rdata)
   );

   nrv_periph_bridge u_bridge (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (periph_req),
      .wdata  (periph_wdata),
      .rdata  (periph_rdata),
      .preq   (gpio_preq),
      .prdata (gpio_rdata)
   );

   nrv_gpio_regs u_gpio (
      .clk     (clk),
      .arst_n  (arst_n),
      .preq    (gpio_preq),
      .prdata  (gpio_rdata),
      .gpio_p0 (gpio_p0),
      .gpio_p1 (gpio_p1)
   );

endmodule

// File: dv/tb_clk_gen.sv
//////////////////////////////////////////////////
// Testbench clock and reset source
// Free running clock, reset held low for a few
// cycles after start
//////////////////////////////////////////////////

module tb_clk_gen #(
   parameter int PERIOD     = 40,
   parameter int RST_CYCLES = 3
) (
   output logic clk,
   output logic arst_n
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #2 arst_n = 1'b1;                        // Release just after an edge
   end

endmodule

// File: dv/tb_nrv_soc.sv
//////////////////////////////////////////////////
// Testbench of the MCU bus fabric
// Drives both master ports, models RAMs and GPIO,
// checks every data phase and the P0 pads
//////////////////////////////////////////////////

module tb_nrv_soc;

   localparam int N_WORDS = 24;                // Random word writes
   localparam int N_PLAN  = 3 * N_WORDS + 44;  // Planned transfers, all tests
   localparam int TIMEOUT = (N_PLAN * 50 + 10) * 40;

   logic clk, arst_n;
   nrv_soc_pkg::ahb_req_t            code_req, data_req;
   logic [nrv_soc_pkg::DATA_W-1:0]   code_wdata, data_wdata;
   nrv_soc_pkg::ahb_rsp_t            code_rsp, data_rsp;
   logic [nrv_soc_pkg::GPIO_W-1:0]   gpio_p0, gpio_p1;

   // Reference state
   logic [7:0]                       mem_m [logic [31:0]];  // Byte addressed, both RAMs
   logic [nrv_soc_pkg::GPIO_W-1:0]   gpio_out_m, gpio_in_m, pad_exp;
   logic [15:0]                      lfsr_q = 16'd6576;

   // Pending data phase per master, 0 code, 1 data
   nrv_soc_pkg::ahb_rsp_t            dp_exp [2];
   logic                             dp_pend [2];
   logic                             dp_rd [2];
   time                              acc_time [2];
   int                               errors = 0;
   int                               checks = 0;
   logic [31:0]                      word_list [$];

   tb_clk_gen #(.PERIOD(40), .RST_CYCLES(3)) u_clk (.clk(clk), .arst_n(arst_n));

   nrv_soc_top u_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .code_req   (code_req),
      .code_wdata (code_wdata),
      .code_rsp   (code_rsp),
      .data_req   (data_req),
      .data_wdata (data_wdata),
      .data_rsp   (data_rsp),
      .gpio_p0    (gpio_p0),
      .gpio_p1    (gpio_p1)
   );

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   // Expected response from the address map, writes update the model
   function automatic nrv_soc_pkg::ahb_rsp_t ref_access(logic wr, nrv_soc_pkg::size_e sz,
                                                        logic [31:0] addr, logic [31:0] wd);
      nrv_soc_pkg::ahb_rsp_t r;
      logic [3:0]            strb;
      logic [31:0]           wa;
      logic [11:0]           ofs;
      r       = '0;
      r.ready = 1'b1;
      strb    = nrv_soc_pkg::byte_strobe(sz, addr[1:0]);
      wa      = {addr[31:2], 2'b00};
      ofs     = {addr[11:2], 2'b00};               // Register word, lanes from strb
      if (addr[31:16] == nrv_soc_pkg::TCM0_BASE[31:16] ||
          addr[31:16] == nrv_soc_pkg::TCM1_BASE[31:16]) begin   // 64 KB RAMs
         for (int b = 0; b < 4; b++) begin
            if (wr && strb[b]) mem_m[wa + b] = wd[8*b +: 8];
            if (!wr) r.rdata[8*b +: 8] = mem_m.exists(wa + b) ? mem_m[wa + b] : 8'h00;
         end
      end else if (addr[31:12] == nrv_soc_pkg::PERIPH_BASE[31:12]) begin
         if (wr && ofs == nrv_soc_pkg::GPIO_OUT_OFS) begin
            for (int b = 0; b < 2; b++) begin
               if (strb[b]) gpio_out_m[8*b +: 8] = wd[8*b +: 8];
            end
         end
         if (!wr && ofs == nrv_soc_pkg::GPIO_OUT_OFS) r.rdata = {16'h0, gpio_out_m};
         if (!wr && ofs == nrv_soc_pkg::GPIO_IN_OFS) r.rdata = {16'h0, gpio_in_m};
      end else begin
         r.resp = 1'b1;                        // Unmapped, rdata stays zero
      end
      return r;
   endfunction

   task automatic check_rsp(string what, nrv_soc_pkg::ahb_rsp_t got,
                            nrv_soc_pkg::ahb_rsp_t exp, logic chk_ready, logic chk_data);
      checks++;
      if ((chk_ready && got.ready !== exp.ready) || got.resp !== exp.resp ||
          (chk_data && got.rdata !== exp.rdata)) begin
         errors++;
         $display("** Error @ %0t: %s got rdy %b resp %b data %h, expected %b %b %h",
                  $time, what, got.ready, got.resp, got.rdata,
                  exp.ready, exp.resp, exp.rdata);
      end
   endtask

   task automatic check_pads(string what, logic [nrv_soc_pkg::GPIO_W-1:0] got,
                             logic [nrv_soc_pkg::GPIO_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error @ %0t: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic drive_req(int m, nrv_soc_pkg::ahb_req_t r);
      if (m == 0) code_req = r;
      else data_req = r;
   endtask

   // One transfer, returns 2 units into its data phase
   task automatic bus_xfer(int m, logic wr, nrv_soc_pkg::size_e sz,
                           logic [31:0] addr, logic [31:0] wd);
      nrv_soc_pkg::ahb_req_t r;
      logic                  acc;
      r.valid = 1'b1;
      r.write = wr;
      r.size  = sz;
      r.addr  = addr;
      drive_req(m, r);
      acc = 1'b0;
      while (!acc) begin
         @(negedge clk);                       // Ready settled here
         acc = (m == 0) ? code_rsp.ready : data_rsp.ready;
         @(posedge clk);
      end
      acc_time[m] = $time;
      #2;
      drive_req(m, '0);
      if (m == 0) code_wdata = wd;
      else data_wdata = wd;
      dp_exp[m]  = ref_access(wr, sz, addr, wd);
      dp_rd[m]   = !wr;
      dp_pend[m] = 1'b1;
   endtask

   function automatic logic [31:0] rand_word_addr();
      logic [31:0] base;
      base = rand_bits(1) ? nrv_soc_pkg::TCM1_BASE : nrv_soc_pkg::TCM0_BASE;
      return base + {rand_bits(14), 2'b00};
   endfunction

   // Compare process, mid cycle where all outputs are stable
   always @(negedge clk) begin
      if (arst_n) begin
         for (int m = 0; m < 2; m++) begin
            if (dp_pend[m]) begin
               check_rsp(m == 0 ? "code data phase" : "data data phase",
                         m == 0 ? code_rsp : data_rsp, dp_exp[m], 1'b0, dp_rd[m]);
               dp_pend[m] = 1'b0;
            end
         end
         check_pads("gpio_p0", gpio_p0, pad_exp);
         pad_exp = gpio_out_m;                 // Written at the end of its data phase
      end
   end

   initial begin
      #(TIMEOUT);
      $display("Timeout: run did not finish within %0d time units", TIMEOUT);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      nrv_soc_pkg::ahb_rsp_t exp;
      logic [31:0]           a, ofs;
      logic                  half;
      code_req   = '0;
      data_req   = '0;
      code_wdata = '0;
      data_wdata = '0;
      gpio_p1    = '0;
      gpio_out_m = '0;
      gpio_in_m  = '0;
      pad_exp    = '0;
      dp_pend[0] = 1'b0;
      dp_pend[1] = 1'b0;
      @(posedge arst_n);
      @(negedge clk);
      exp       = '0;
      exp.ready = 1'b1;
      check_rsp("code after reset", code_rsp, exp, 1'b1, 1'b1);
      check_rsp("data after reset", data_rsp, exp, 1'b1, 1'b1);
      @(posedge clk);
      #2;

      // Random words in, read back on both sides
      for (int i = 0; i < N_WORDS; i++) begin
         a = rand_word_addr();
         word_list.push_back(a);
         bus_xfer(1, 1'b1, nrv_soc_pkg::SZ_WORD, a, rand_bits(32));
      end
      foreach (word_list[i]) begin
         bus_xfer(0, 1'b0, nrv_soc_pkg::SZ_WORD, word_list[i], '0);
         bus_xfer(1, 1'b0, nrv_soc_pkg::SZ_WORD, word_list[i], '0);
      end

      // Byte and halfword merges
      for (int i = 0; i < 8; i++) begin
         half = rand_bits(1);
         ofs  = half ? {rand_bits(1), 1'b0} : rand_bits(2);
         a    = word_list[i] + ofs;
         bus_xfer(1, 1'b1, half ? nrv_soc_pkg::SZ_HALF : nrv_soc_pkg::SZ_BYTE, a, rand_bits(32));
         bus_xfer(0, 1'b0, nrv_soc_pkg::SZ_WORD, word_list[i], '0);
      end

      // Write then read of the same word, back to back
      for (int i = 8; i < 14; i++) begin
         bus_xfer(1, 1'b1, (i % 2) ? nrv_soc_pkg::SZ_BYTE : nrv_soc_pkg::SZ_WORD,
                  word_list[i] + (i % 2) * 3, rand_bits(32));
         bus_xfer(1, 1'b0, nrv_soc_pkg::SZ_WORD, word_list[i], '0);
      end

      // Same slave from both masters
      for (int i = 14; i < 16; i++) begin
         fork
            bus_xfer(1, i == 14, nrv_soc_pkg::SZ_WORD, word_list[i], rand_bits(32));
            bus_xfer(0, 1'b0, nrv_soc_pkg::SZ_WORD, word_list[i], '0);
            begin
               @(negedge clk);
               exp       = '0;
               exp.ready = 1'b0;
               check_rsp("code ready in collision", code_rsp, exp, 1'b1, 1'b0);
               exp.ready = 1'b1;
               check_rsp("data ready in collision", data_rsp, exp, 1'b1, 1'b0);
            end
         join
         if (acc_time[1] >= acc_time[0]) begin
            errors++;
            $display("Collision at %0t: the data side was not served before the code side",
                     $time);
         end
      end

      // GPIO out, partial write, input sync
      bus_xfer(1, 1'b1, nrv_soc_pkg::SZ_WORD, 32'h8000_0000, rand_bits(32));
      bus_xfer(1, 1'b0, nrv_soc_pkg::SZ_WORD, 32'h8000_0000, '0);
      bus_xfer(1, 1'b1, nrv_soc_pkg::SZ_BYTE, 32'h8000_0001, 32'h0000_a500);
      bus_xfer(0, 1'b0, nrv_soc_pkg::SZ_WORD, 32'h8000_0000, '0);
      gpio_p1   = rand_bits(16);
      gpio_in_m = gpio_p1;
      repeat (4) @(posedge clk);
      #2;
      bus_xfer(1, 1'b0, nrv_soc_pkg::SZ_WORD, 32'h8000_0004, '0);
      bus_xfer(1, 1'b1, nrv_soc_pkg::SZ_WORD, 32'h8000_0004, 32'hffff_ffff);  // Ignored
      bus_xfer(0, 1'b0, nrv_soc_pkg::SZ_WORD, 32'h8000_0004, '0);
      bus_xfer(1, 1'b0, nrv_soc_pkg::SZ_WORD, 32'h8000_0008, '0);   // Empty offset

      // Unmapped space
      bus_xfer(1, 1'b0, nrv_soc_pkg::SZ_WORD, 32'h4000_0000, '0);
      a = {16'h0002, word_list[0][15:0]};       // Same RAM offset as word_list[0]
      bus_xfer(1, 1'b1, nrv_soc_pkg::SZ_WORD, a, 32'hdead_beef);
      bus_xfer(0, 1'b0, nrv_soc_pkg::SZ_WORD, a, '0);
      bus_xfer(1, 1'b0, nrv_soc_pkg::SZ_WORD, word_list[0], '0);

      repeat (2) @(posedge clk);               // Drain last data phase
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: project.f
src/nrv_soc_pkg.sv
src/nrv_ahb_matrix.sv
src/nrv_tcm_ram.sv
src/nrv_periph_bridge.sv
src/nrv_gpio_regs.sv
src/nrv_soc_top.sv
dv/tb_clk_gen.sv
dv/tb_nrv_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_nrv_soc -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
   exit 0
fi
echo "Pass message not found"
exit 1
